// ==== vlog.f ====
hw/cpuPkg.sv
hw/ctrlPkg.sv
hw/phaseSequencer.sv
hw/programCounter.sv
hw/loadStoreDecoder.sv
hw/registerFile.sv
hw/addressUnit.sv
hw/loadStoreCore.sv
verif/loadStoreCore_props.sv
verif/loadStoreCore_tb.sv

// ==== verif/loadStoreCore_tb.sv ====
`default_nettype none

module loadStoreCore_tb;
	import cpuPkg::*;

	localparam logic [15:0] startAddr = 16'h0100;
	localparam int seedCount = 15;
	localparam int directedCount = 11;
	localparam int randomCount = 200;
	localparam int instrCount = seedCount + directedCount + randomCount;
	localparam int cycleLimit = 16 + 4 * instrCount + 50;

	logic        CLK;
	logic        rstN;
	instrT       instr;
	logic [15:0] memRdata;
	logic        fetch;
	logic [15:0] instrAddr;
	logic [15:0] memAddr;
	logic [15:0] memWdata;
	logic        memRd;
	logic        memWr;

	// Reference state
	logic [15:0] mem [65536];
	logic [15:0] regs [16];
	logic [15:0] pc;
	logic [31:0] lfsr;
	int          cycles = 0;

	loadStoreCore #(
		.resetAddr (startAddr)
	) dut_i (
		.CLK       (CLK),
		.rstN      (rstN),
		.instr     (instr),
		.memRdata  (memRdata),
		.fetch     (fetch),
		.instrAddr (instrAddr),
		.memAddr   (memAddr),
		.memWdata  (memWdata),
		.memRd     (memRd),
		.memWr     (memWr)
	);

	// Data memory answers in the same cycle
	assign memRdata = mem[memAddr];

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles > cycleLimit) begin
			$display("Timeout: the instruction sequence did not finish in %0d cycles", cycleLimit);
			$display("Testbench failed");
			$fatal(1, "Run stopped by the cycle limit");
		end else if (dut_i.props_i.failCount != 0) begin
			$display("Protocol assertion failed in the bound checker");
			$display("Testbench failed");
			$fatal(1, "Stopped at the first protocol error");
		end
	end

	// Galois LFSR, one step per bit taken
	function automatic logic [15:0] takeBits(input int count);
		logic [15:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[14:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
		end
		return bits;
	endfunction

	function automatic instrT makeInstr(input groupT group, input incModeT incMode,
			input lsOpT op, input lsModeT mode, input logic [3:0] ra, input logic [3:0] rb);
		return '{group, incMode, op, mode, ra, rb};
	endfunction

	function automatic instrT randomInstr();
		logic [15:0] pick;
		logic [15:0] incBits;
		logic [15:0] opBits;
		logic [15:0] modeBits;
		logic [15:0] raBits;
		logic [15:0] rbBits;
		groupT       group;
		pick = takeBits(4);
		incBits = takeBits(2);
		opBits = takeBits(1);
		modeBits = takeBits(2);
		raBits = takeBits(4);
		rbBits = takeBits(4);
		// Mostly load/store, a few other groups as no-ops
		case (pick[3:0])
			4'd0:    group = GROUP_GENERAL;
			4'd1:    group = GROUP_ALU;
			4'd2:    group = GROUP_BRANCH;
			default: group = GROUP_LOAD_STORE;
		endcase
		return makeInstr(group, incModeT'(incBits[1:0]), lsOpT'(opBits[0]),
			lsModeT'({1'b0, modeBits[1:0]}), raBits[3:0], rbBits[3:0]);
	endfunction

	task automatic checkValue(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		assert (got === exp) else begin
			$display("** Error: %s is %h, expected %h", name, got, exp);
			$display("Testbench failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Runs one instruction from the edge that opens FETCH to the edge that ends COMMIT
	task automatic issueInstr(input instrT ins);
		logic        isLs;
		logic        ptrUpdate;
		logic [15:0] base;
		logic [15:0] addr;
		logic [15:0] newPtr;
		logic [15:0] loaded;
		logic [15:0] offset2;
		instr <= ins;
		isLs = (ins.group == GROUP_LOAD_STORE);
		// Twice the word offset
		offset2 = 16'(ins.rbOrOffset) * 16'd2;
		ptrUpdate = 1'b0;
		base = regs[ins.rbOrOffset];
		addr = base;
		newPtr = base;
		case (ins.incMode)
			PRE_DEC: begin
				addr = base - 16'd2;
				newPtr = addr;
				ptrUpdate = 1'b1;
			end
			POST_INC: begin
				newPtr = base + 16'd2;
				ptrUpdate = 1'b1;
			end
			OFFSET: begin
				case (ins.mode)
					REG_FRAME:    addr = regs[RFP] - offset2;
					REG_STACK:    addr = regs[RSP] + offset2;
					REG_RETSTACK: addr = regs[RRS] + offset2;
					default:      addr = base;
				endcase
			end
			default: addr = base;
		endcase

		@(negedge CLK);
		checkValue("fetch", fetch, 1'b1);
		checkValue("instrAddr", instrAddr, pc);
		checkValue("memRd", memRd, 1'b0);
		checkValue("memWr", memWr, 1'b0);
		@(negedge CLK);
		checkValue("fetch", fetch, 1'b0);
		checkValue("memRd", memRd, 1'b0);
		checkValue("memWr", memWr, 1'b0);
		// EXECUTE
		@(negedge CLK);
		checkValue("fetch", fetch, 1'b0);
		checkValue("memRd", memRd, isLs && (ins.op == LD));
		checkValue("memWr", memWr, isLs && (ins.op == ST));
		if (isLs) begin
			checkValue("memAddr", memAddr, addr);
			if (ins.op == ST) begin
				checkValue("memWdata", memWdata, regs[ins.ra]);
			end
		end
		loaded = mem[addr];
		@(posedge CLK);
		if (isLs && (ins.op == ST)) begin
			mem[addr] <= regs[ins.ra];
		end
		// COMMIT
		@(negedge CLK);
		checkValue("fetch", fetch, 1'b0);
		checkValue("memRd", memRd, 1'b0);
		checkValue("memWr", memWr, 1'b0);
		@(posedge CLK);
		// Pointer first so a load into the same register wins
		if (isLs && ptrUpdate) begin
			regs[ins.rbOrOffset] = newPtr;
		end
		if (isLs && (ins.op == LD)) begin
			regs[ins.ra] = loaded;
		end
		pc = pc + 16'd1;
	endtask

	initial begin
		rstN <= 1'b0;
		instr <= '0;
		lfsr = 32'd93113;
		pc = startAddr;
		for (int i = 0; i < 16; i++) begin
			regs[i] = '0;
		end
		for (int a = 0; a < 65536; a++) begin
			mem[a] = 16'(a) ^ 16'hA5C3;
		end
		repeat (15) @(posedge CLK);
		@(negedge CLK);
		checkValue("instrAddr", instrAddr, startAddr);
		checkValue("memRd", memRd, 1'b0);
		checkValue("memWr", memWr, 1'b0);
		@(posedge CLK);
		rstN <= 1'b1;

		// Seed r1..r15 by walking (r0++) through memory
		for (int k = 1; k <= seedCount; k++) begin
			issueInstr(makeInstr(GROUP_LOAD_STORE, POST_INC, LD, REG_MEM, 4'(k), 4'd0));
		end

		issueInstr(makeInstr(GROUP_LOAD_STORE, PRE_DEC, LD, REG_MEM, 4'd2, 4'd1));
		issueInstr(makeInstr(GROUP_LOAD_STORE, NONE, ST, REG_MEM, 4'd2, 4'd1));
		issueInstr(makeInstr(GROUP_LOAD_STORE, POST_INC, ST, REG_MEM, 4'd3, 4'd1));
		issueInstr(makeInstr(GROUP_LOAD_STORE, NONE, ST, REG_MEM, 4'd4, 4'd1));
		issueInstr(makeInstr(GROUP_LOAD_STORE, OFFSET, LD, REG_FRAME, 4'd5, 4'd3));
		issueInstr(makeInstr(GROUP_LOAD_STORE, OFFSET, ST, REG_STACK, 4'd5, 4'd7));
		issueInstr(makeInstr(GROUP_LOAD_STORE, OFFSET, LD, REG_RETSTACK, 4'd6, 4'd15));
		issueInstr(makeInstr(GROUP_ALU, POST_INC, LD, REG_MEM, 4'd7, 4'd8));
		// r7 and r8 untouched by the ALU-group word
		issueInstr(makeInstr(GROUP_LOAD_STORE, NONE, ST, REG_MEM, 4'd7, 4'd8));
		// Load and pointer update on one register, then use it as the pointer
		issueInstr(makeInstr(GROUP_LOAD_STORE, PRE_DEC, LD, REG_MEM, 4'd9, 4'd9));
		issueInstr(makeInstr(GROUP_LOAD_STORE, NONE, ST, REG_MEM, 4'd9, 4'd9));

		repeat (randomCount) begin
			issueInstr(randomInstr());
		end

		// Let the checker finish the last edge
		@(negedge CLK);
		if (dut_i.props_i.failCount == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("Testbench failed");
			$fatal(1, "Protocol assertions reported errors");
		end
	end

endmodule

`default_nettype wire

// ==== verif/loadStoreCore_props.sv ====
`default_nettype none

module loadStoreCore_props (
	input logic          CLK,
	input logic          rstN,
	input cpuPkg::phaseT phase,
	input cpuPkg::instrT instrReg,
	input logic          fetch,
	input logic          memRd,
	input logic          memWr
);
	import cpuPkg::*;

	int failCount = 0;

	// Fixed four-phase rotation
	fetchToDecode: assert property (@(posedge CLK) disable iff (!rstN)
		(phase == FETCH) |=> (phase == DECODE))
	else begin
		$error("phase left FETCH for something other than DECODE");
		failCount++;
	end

	decodeToExecute: assert property (@(posedge CLK) disable iff (!rstN)
		(phase == DECODE) |=> (phase == EXECUTE))
	else begin
		$error("phase left DECODE for something other than EXECUTE");
		failCount++;
	end

	executeToCommit: assert property (@(posedge CLK) disable iff (!rstN)
		(phase == EXECUTE) |=> (phase == COMMIT))
	else begin
		$error("phase left EXECUTE for something other than COMMIT");
		failCount++;
	end

	commitToFetch: assert property (@(posedge CLK) disable iff (!rstN)
		(phase == COMMIT) |=> (phase == FETCH))
	else begin
		$error("phase left COMMIT for something other than FETCH");
		failCount++;
	end

	// One fetch cycle in every four
	fetchEveryFourth: assert property (@(posedge CLK) disable iff (!rstN)
		fetch |=> !fetch ##1 !fetch ##1 !fetch ##1 fetch)
	else begin
		$error("fetch did not come back after exactly four cycles");
		failCount++;
	end

	// Strobes only in EXECUTE, never both, only for load/store
	strobeInExecute: assert property (@(posedge CLK) disable iff (!rstN)
		(memRd || memWr) |-> (phase == EXECUTE))
	else begin
		$error("memory strobe outside EXECUTE");
		failCount++;
	end

	strobeExclusive: assert property (@(posedge CLK) disable iff (!rstN)
		!(memRd && memWr))
	else begin
		$error("memRd and memWr high together");
		failCount++;
	end

	strobeLoadStoreOnly: assert property (@(posedge CLK) disable iff (!rstN)
		(memRd || memWr) |-> (instrReg.group == GROUP_LOAD_STORE))
	else begin
		$error("memory strobe for an instruction outside the load/store group");
		failCount++;
	end

endmodule

bind loadStoreCore loadStoreCore_props props_i (
	.CLK      (CLK),
	.rstN     (rstN),
	.phase    (phase),
	.instrReg (instrReg),
	.fetch    (fetch),
	.memRd    (memRd),
	.memWr    (memWr)
);

`default_nettype wire

// ==== hw/loadStoreCore.sv ====
`default_nettype none

module loadStoreCore #(
	parameter logic [15:0] resetAddr = 16'h0000
) (
	input  logic          CLK,
	input  logic          rstN,
	input  cpuPkg::instrT instr,
	input  logic [15:0]   memRdata,
	output logic          fetch,
	output logic [15:0]   instrAddr,
	output logic [15:0]   memAddr,
	output logic [15:0]   memWdata,
	output logic          memRd,
	output logic          memWr
);
	import cpuPkg::*;
	import ctrlPkg::*;

	phaseT       phase;
	instrT       instrReg;
	ctrlT        ctrl;
	logic [3:0]  regbNum;
	logic [15:0] regaData;
	logic [15:0] regbData;
	logic [15:0] aluResult;
	logic [15:0] loadData;

	phaseSequencer phaseSequencer_i (
		.CLK   (CLK),
		.rstN  (rstN),
		.phase (phase)
	);

	programCounter #(
		.resetAddr (resetAddr)
	) programCounter_i (
		.CLK       (CLK),
		.rstN      (rstN),
		.phase     (phase),
		.instrAddr (instrAddr)
	);

	// Instruction register, loaded at the end of FETCH
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			instrReg <= '0;
		end else if (phase == FETCH) begin
			instrReg <= instr;
		end
	end

	assign fetch = (phase == FETCH);

	loadStoreDecoder loadStoreDecoder_i (
		.phase (phase),
		.instr (instrReg),
		.ctrl  (ctrl)
	);

	// Port B select to a register number
	always_comb begin
		case (ctrl.regbAddr)
			ctrlPkg::RFP: regbNum = cpuPkg::RFP;
			ctrlPkg::RSP: regbNum = cpuPkg::RSP;
			ctrlPkg::RRS: regbNum = cpuPkg::RRS;
			default:      regbNum = instrReg.rbOrOffset;
		endcase
	end

	registerFile registerFile_i (
		.CLK      (CLK),
		.rstN     (rstN),
		.ctrl     (ctrl),
		.regaAddr (instrReg.ra),
		.regbAddr (regbNum),
		.regaDin  (loadData),
		.regbDin  (aluResult),
		.regaData (regaData),
		.regbData (regbData)
	);

	addressUnit addressUnit_i (
		.CLK       (CLK),
		.rstN      (rstN),
		.ctrl      (ctrl),
		.offset    (instrReg.rbOrOffset),
		.regbData  (regbData),
		.memRdata  (memRdata),
		.aluResult (aluResult),
		.memAddr   (memAddr),
		.loadData  (loadData)
	);

	assign memWdata = regaData;
	assign memRd    = ctrl.memRd;
	assign memWr    = ctrl.memWr;

endmodule

`default_nettype wire

// ==== hw/addressUnit.sv ====
`default_nettype none

module addressUnit (
	input  logic          CLK,
	input  logic          rstN,
	input  ctrlPkg::ctrlT ctrl,
	input  logic [3:0]    offset,
	input  logic [15:0]   regbData,
	input  logic [15:0]   memRdata,
	output logic [15:0]   aluResult,
	output logic [15:0]   memAddr,
	output logic [15:0]   loadData
);
	import ctrlPkg::*;

	logic        access;
	logic [15:0] aluaNow;
	logic [15:0] aluaHeld;
	logic [15:0] baseHeld;
	logic [15:0] aluA;
	logic [15:0] aluB;

	// A strobe marks the EXECUTE cycle of a load or store
	assign access = ctrl.memRd | ctrl.memWr;

	always_comb begin
		case (ctrl.aluaSrc)
			TWO:     aluaNow = 16'd2;
			// Word offset scaled to bytes
			OFFSET2: aluaNow = {11'd0, offset, 1'b0};
			default: aluaNow = 16'd0;
		endcase
	end

	// Live operands in EXECUTE, held copies afterwards
	assign aluA = access ? aluaNow : aluaHeld;
	assign aluB = access ? regbData : baseHeld;

	assign aluResult = (ctrl.aluOp == SUB) ? (aluB - aluA) : (aluB + aluA);
	assign memAddr   = (ctrl.addrBus == ALU_RESULT) ? aluResult : regbData;

	always_ff @(posedge CLK) begin
		if (access) begin
			aluaHeld <= aluaNow;
			baseHeld <= regbData;
		end
	end

	// Read data kept for the COMMIT write to Ra
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			loadData <= '0;
		end else if (ctrl.memRd) begin
			loadData <= memRdata;
		end
	end

endmodule

`default_nettype wire

// ==== hw/registerFile.sv ====
`default_nettype none

module registerFile (
	input  logic          CLK,
	input  logic          rstN,
	input  ctrlPkg::ctrlT ctrl,
	input  logic [3:0]    regaAddr,
	input  logic [3:0]    regbAddr,
	input  logic [15:0]   regaDin,
	input  logic [15:0]   regbDin,
	output logic [15:0]   regaData,
	output logic [15:0]   regbData
);
	import ctrlPkg::*;

	logic [15:0] regs [16];
	logic        regaWrite;
	logic        regbWrite;

	assign regaWrite = ctrl.regaEn && ctrl.regaWen;
	assign regbWrite = ctrl.regbEn && ctrl.regbWen;

	// Reads are combinational
	assign regaData = regs[regaAddr];
	assign regbData = regs[regbAddr];

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (regbWrite) begin
				regs[regbAddr] <= regbDin;
			end
			// Port A last so it wins when both hit one register
			if (regaWrite) begin
				regs[regaAddr] <= regaDin;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/loadStoreDecoder.sv ====
`default_nettype none

module loadStoreDecoder (
	input  cpuPkg::phaseT phase,
	input  cpuPkg::instrT instr,
	output ctrlPkg::ctrlT ctrl
);
	import cpuPkg::*;
	import ctrlPkg::*;

	logic isLoadStore;
	logic ptrUpdate;

	assign isLoadStore = (instr.group == GROUP_LOAD_STORE);
	assign ptrUpdate   = (instr.incMode == PRE_DEC) || (instr.incMode == POST_INC);

	always_comb begin
		// Plain (Rb) access unless the instruction says otherwise
		ctrl          = '0;
		ctrl.aluOp    = ADD;
		ctrl.aluaSrc  = ZERO;
		ctrl.addrBus  = REGB_DATA;
		ctrl.regbAddr = ARGB;

		if (isLoadStore) begin
			case (instr.incMode)
				PRE_DEC: begin
					// Address is the decremented pointer
					ctrl.aluaSrc = TWO;
					ctrl.aluOp   = SUB;
					ctrl.addrBus = ALU_RESULT;
				end
				POST_INC: begin
					// Old pointer goes out, Rb+2 written back
					ctrl.aluaSrc = TWO;
				end
				OFFSET: begin
					ctrl.aluaSrc = OFFSET2;
					ctrl.addrBus = ALU_RESULT;
					case (instr.mode)
						REG_FRAME: begin
							// Frame locals sit below FP
							ctrl.aluOp    = SUB;
							ctrl.regbAddr = ctrlPkg::RFP;
						end
						REG_STACK: begin
							ctrl.regbAddr = ctrlPkg::RSP;
						end
						REG_RETSTACK: begin
							ctrl.regbAddr = ctrlPkg::RRS;
						end
						default: begin
							// No base register, same as (Rb)
							ctrl.aluaSrc = ZERO;
							ctrl.addrBus = REGB_DATA;
						end
					endcase
				end
				default: begin
					ctrl.aluaSrc = ZERO;
				end
			endcase

			case (phase)
				EXECUTE: begin
					ctrl.regaEn = 1'b1;
					ctrl.regbEn = 1'b1;
					ctrl.memRd  = (instr.op == LD);
					ctrl.memWr  = (instr.op == ST);
				end
				COMMIT: begin
					// Ports stay enabled for the write-back
					ctrl.regaEn  = 1'b1;
					ctrl.regbEn  = 1'b1;
					ctrl.regaWen = (instr.op == LD);
					ctrl.regbWen = ptrUpdate;
				end
				default: begin
					ctrl.regaEn = 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/programCounter.sv ====
`default_nettype none

module programCounter #(
	parameter logic [15:0] resetAddr = 16'h0000
) (
	input  logic          CLK,
	input  logic          rstN,
	input  cpuPkg::phaseT phase,
	output logic [15:0]   instrAddr
);
	import cpuPkg::*;

	// Steps on the edge that ends COMMIT so the next FETCH sees the new address
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			instrAddr <= resetAddr;
		end else if (phase == COMMIT) begin
			instrAddr <= instrAddr + 16'd1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/phaseSequencer.sv ====
`default_nettype none

module phaseSequencer (
	input  logic          CLK,
	input  logic          rstN,
	output cpuPkg::phaseT phase
);
	import cpuPkg::*;

	phaseT nextPhase;

	// Fixed rotation, nothing can hold it
	always_comb begin
		case (phase)
			FETCH:   nextPhase = DECODE;
			DECODE:  nextPhase = EXECUTE;
			EXECUTE: nextPhase = COMMIT;
			default: nextPhase = FETCH;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			phase <= FETCH;
		end else begin
			phase <= nextPhase;
		end
	end

endmodule

`default_nettype wire

// ==== hw/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

	typedef enum logic {
		ADD = 1'b0,
		SUB = 1'b1
	} aluOpT;

	// Operand A of the address adder
	typedef enum logic [1:0] {
		ZERO    = 2'd0,
		TWO     = 2'd1,
		OFFSET2 = 2'd2
	} aluaSrcT;

	// Where the memory address comes from
	typedef enum logic {
		REGB_DATA  = 1'b0,
		ALU_RESULT = 1'b1
	} addrBusT;

	// Register number used by port B
	typedef enum logic [1:0] {
		ARGB = 2'd0,
		RFP  = 2'd1,
		RSP  = 2'd2,
		RRS  = 2'd3
	} regbAddrT;

	typedef struct packed {
		logic     regaEn;
		logic     regbEn;
		logic     regaWen;
		logic     regbWen;
		aluOpT    aluOp;
		aluaSrcT  aluaSrc;
		addrBusT  addrBus;
		regbAddrT regbAddr;
		logic     memRd;
		logic     memWr;
	} ctrlT;

endpackage

`default_nettype wire

// ==== hw/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

	// Instruction phases, one clock each
	typedef enum logic [1:0] {
		FETCH   = 2'b00,
		DECODE  = 2'b01,
		EXECUTE = 2'b10,
		COMMIT  = 2'b11
	} phaseT;

	// Instruction group in bits 15:14
	typedef enum logic [1:0] {
		GROUP_GENERAL    = 2'b00,
		GROUP_LOAD_STORE = 2'b01,
		GROUP_ALU        = 2'b10,
		GROUP_BRANCH     = 2'b11
	} groupT;

	// Pointer update field, bits 13:12
	typedef enum logic [1:0] {
		NONE     = 2'b00,
		PRE_DEC  = 2'b01,
		OFFSET   = 2'b10,
		POST_INC = 2'b11
	} incModeT;

	typedef enum logic {
		LD = 1'b0,
		ST = 1'b1
	} lsOpT;

	// Base register choice for offset forms
	typedef enum logic [2:0] {
		REG_MEM      = 3'd0,
		REG_FRAME    = 3'd1,
		REG_STACK    = 3'd2,
		REG_RETSTACK = 3'd3
	} lsModeT;

	typedef struct packed {
		groupT       group;
		incModeT     incMode;
		lsOpT        op;
		lsModeT      mode;
		logic [3:0]  ra;
		logic [3:0]  rbOrOffset;
	} instrT;

	// Frame, data stack and return stack pointers
	localparam logic [3:0] RFP = 4'd13;
	localparam logic [3:0] RSP = 4'd14;
	localparam logic [3:0] RRS = 4'd15;

endpackage

`default_nettype wire
